// ==== AesEncryptPipe.sv ====
`timescale 1ns/1ps

module AesEncryptPipe
    import AesPkg::*;
(
    input  logic    clock,
    input  logic    rstN,
    input  encIn_t  encIn,
    output encOut_t encOut
);

    roundKey_t [0:NUM_ROUNDS] roundKeys;

    // Entry 0 is the incoming block, entry i is the output of stage i
    cipherStage_t stages [0:NUM_ROUNDS];

    //**************************************************************************
    // Key schedule
    //**************************************************************************
    KeyExpansion u_keyExpansion (
        .clock(clock),
        .rstN(rstN),
        .key(encIn.key),
        .roundKeys(roundKeys)
    );

    //**************************************************************************
    // Cipher rounds
    //**************************************************************************

    // Plaintext enters with its valid bit
    assign stages[0] = {encIn.valid, encIn.plaintext};

    // Stage i and key round i-1 are both i-1 cycles behind the input
    // so each stage sees the round key of its own block
    for (genvar i = 1; i <= NUM_ROUNDS; i++)
    begin : gCipherRound
        CipherRound #(
            .lastRound(i == NUM_ROUNDS)
        ) u_cipherRound (
            .clock(clock),
            .rstN(rstN),
            .roundKey(roundKeys[i - 1]),
            .stageIn(stages[i - 1]),
            .stageOut(stages[i])
        );
    end

    //**************************************************************************
    // Output
    //**************************************************************************

    // Last AddRoundKey stays combinational after the stage 10 register
    // Key round 10 loaded on the same edge, so its key belongs to this block
    assign encOut = {
        stages[NUM_ROUNDS].valid,
        stages[NUM_ROUNDS].state.bytes ^ roundKeys[NUM_ROUNDS]
    };

endmodule

// ==== AesTbVectors.svh ====
`ifndef AES_TB_VECTORS_SVH
`define AES_TB_VECTORS_SVH

// One known answer, all fields in FIPS-197 byte order
typedef struct packed
{
    block_t key;
    block_t plaintext;
    block_t ciphertext;
} tbVector_t;

localparam int NUM_VECTORS = 7;

localparam tbVector_t TB_VECTORS [0:NUM_VECTORS-1] = '{
    // FIPS-197 Appendix B
    '{key:        128'h2b7e151628aed2a6abf7158809cf4f3c,
      plaintext:  128'h3243f6a8885a308d313198a2e0370734,
      ciphertext: 128'h3925841d02dc09fbdc118597196a0b32},
    // FIPS-197 Appendix C.1
    '{key:        128'h000102030405060708090a0b0c0d0e0f,
      plaintext:  128'h00112233445566778899aabbccddeeff,
      ciphertext: 128'h69c4e0d86a7b0430d8cdb78070b4c55a},
    // SP800-38A ECB-AES128 block 1
    '{key:        128'h2b7e151628aed2a6abf7158809cf4f3c,
      plaintext:  128'h6bc1bee22e409f96e93d7e117393172a,
      ciphertext: 128'h3ad77bb40d7a3660a89ecaf32466ef97},
    // Block 2
    '{key:        128'h2b7e151628aed2a6abf7158809cf4f3c,
      plaintext:  128'hae2d8a571e03ac9c9eb76fac45af8e51,
      ciphertext: 128'hf5d3d58503b9699de785895a96fdbaaf},
    // Block 3
    '{key:        128'h2b7e151628aed2a6abf7158809cf4f3c,
      plaintext:  128'h30c81c46a35ce411e5fbc1191a0a52ef,
      ciphertext: 128'h43b1cd7f598ece23881b00e3ed030688},
    // Block 4
    '{key:        128'h2b7e151628aed2a6abf7158809cf4f3c,
      plaintext:  128'hf69f2445df4f9b17ad2b417be66c3710,
      ciphertext: 128'h7b0c785e27e8ad3f8223207104725dd4},
    // All-zero key and plaintext
    '{key:        128'h00000000000000000000000000000000,
      plaintext:  128'h00000000000000000000000000000000,
      ciphertext: 128'h66e94bd4ef8a2c3b884cfa59ca342b2e}
};

`endif

// ==== AesEncryptTb.sv ====
`timescale 1ns/1ps

module AesEncryptTb
    import AesPkg::*;
;

    `include "AesTbVectors.svh"

    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 3;
    localparam logic [31:0] LFSR_SEED = 32'd83709;

    // Rows in flight when the mid-stream reset hits
    localparam int FLUSH_ROWS = 5;

    // Single rows need a full trip each, the other passes stream
    // Gapped pass needs a few slots per row, plus reset and drains
    localparam int TIMEOUT_CYCLES = NUM_VECTORS * (NUM_ROUNDS + 12) + 6 * NUM_ROUNDS + 40;

    logic    clock;
    logic    rstN;
    encIn_t  encIn;
    encOut_t encOut;

    // Ciphertexts of blocks sent but not yet seen at the output
    block_t expectedQ [$];
    block_t headValue;

    // Input valid delayed edge by edge, index i is the valid of stage i
    logic expValid [1:NUM_ROUNDS];

    logic [31:0] lfsr;
    logic        gate;
    int          row;

    AesEncryptPipe u_AesEncryptPipe (
        .clock(clock),
        .rstN(rstN),
        .encIn(encIn),
        .encOut(encOut)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    //**************************************************************************
    // Helpers
    //**************************************************************************

    // Right-shifting Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic abortRun();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkEqual(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
            abortRun();
        end
    endtask

    // One input slot, a valid slot also queues its answer
    task automatic driveSlot(input int r, input logic v);
        @(posedge clock);
        encIn <= {v, TB_VECTORS[r].key, TB_VECTORS[r].plaintext};
        if (v)
        begin
            expectedQ.push_back(TB_VECTORS[r].ciphertext);
        end
    endtask

    task automatic driveIdle();
        @(posedge clock);
        encIn.valid <= 1'b0;
    endtask

    // Every table row on back to back edges
    task automatic sendBurst();
        for (int r = 0; r < NUM_VECTORS; r++)
        begin
            driveSlot(r, 1'b1);
        end
        driveIdle();
    endtask

    // Returns once every queued block has come out
    task automatic waitDrain();
        while (expectedQ.size() != 0)
        begin
            @(posedge clock);
        end
    endtask

    //**************************************************************************
    // Expected valid pattern
    //**************************************************************************

    // Input valid reaches the output ten edges after capture
    // a reset edge drops everything in flight
    always @(posedge clock)
    begin
        for (int i = NUM_ROUNDS; i > 1; i--)
        begin
            expValid[i] = expValid[i - 1];
        end
        expValid[1] = rstN ? encIn.valid : 1'b0;
        if (!rstN)
        begin
            for (int i = 1; i <= NUM_ROUNDS; i++)
            begin
                expValid[i] = 1'b0;
            end
        end
    end

    //**************************************************************************
    // Output monitor
    //**************************************************************************

    // Sampled mid-cycle, well away from the driving edge
    always @(negedge clock)
    begin
        if (encOut.valid === 1'b1 && expectedQ.size() == 0)
        begin
            $display("Output appeared at %0t with no block pending", $time);
            abortRun();
        end
        checkEqual("encOut.valid", encOut.valid, expValid[NUM_ROUNDS]);
        if (encOut.valid)
        begin
            headValue = expectedQ.pop_front();
            checkEqual("encOut.ciphertext", encOut.ciphertext, headValue);
        end
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        abortRun();
    end

    //**************************************************************************
    // Stimulus
    //**************************************************************************
    initial
    begin
        clock = 1'b0;
        rstN = 1'b0;
        encIn = '0;
        lfsr = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge clock);
        rstN <= 1'b1;

        // Known answers, one row alone at a time
        for (int r = 0; r < NUM_VECTORS; r++)
        begin
            driveSlot(r, 1'b1);
            driveIdle();
            waitDrain();
        end

        // Back to back, key changes on every edge
        sendBurst();
        waitDrain();

        // Gapped stream, one LFSR bit per slot
        // A set bit makes the slot a gap
        row = 0;
        while (row < NUM_VECTORS)
        begin
            lfsr = galoisStep(lfsr);
            gate = ~lfsr[0];
            driveSlot(row, gate);
            if (gate)
            begin
                row++;
            end
        end
        driveIdle();
        waitDrain();

        // Reset with blocks still in the pipe
        for (int r = 0; r < FLUSH_ROWS; r++)
        begin
            driveSlot(r, 1'b1);
        end
        @(posedge clock);
        rstN <= 1'b0;
        encIn.valid <= 1'b0;
        // First low edge flushes the pipe, its blocks never come out
        @(posedge clock);
        expectedQ.delete();
        repeat (RESET_CYCLES - 1) @(posedge clock);
        rstN <= 1'b1;
        repeat (NUM_ROUNDS)
        begin
            @(negedge clock);
            checkEqual("encOut.valid", encOut.valid, 1'b0);
        end

        // Pipe must work normally again
        sendBurst();
        waitDrain();
        repeat (2) @(negedge clock);

        if (expectedQ.size() == 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
        begin
            $display("Blocks still pending at the end of the run: %0d", expectedQ.size());
            abortRun();
        end
    end

endmodule

// ==== AesPkg.sv ====
package AesPkg;

    //**************************************************************************
    // Sizes and types
    //**************************************************************************

    // AES-128 round count
    localparam int NUM_ROUNDS = 10;

    typedef logic [7:0] byte_t;

    // One column, byte 0 is the top row
    typedef byte_t [0:3] word_t;

    // Byte 0 sits in the MSBs, FIPS-197 input order
    typedef byte_t [0:15] block_t;
    typedef block_t roundKey_t;

    // Byte view for SubBytes and ShiftRows
    // Column view for MixColumns and key schedule words
    typedef union packed
    {
        block_t bytes;
        word_t [0:3] cols;
    } state_u;

    // Travels between cipher rounds
    typedef struct packed
    {
        logic valid;
        state_u state;
    } cipherStage_t;

    // Top level input bundle, each block brings its own key
    typedef struct packed
    {
        logic valid;
        block_t key;
        block_t plaintext;
    } encIn_t;

    typedef struct packed
    {
        logic valid;
        block_t ciphertext;
    } encOut_t;

    //**************************************************************************
    // Constant tables
    //**************************************************************************

    // Round constants, index is the key round number
    localparam byte_t RCON [1:NUM_ROUNDS] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // Forward S-box, row is the high nibble
    localparam byte_t SBOX [0:255] = '{
        'h63, 'h7c, 'h77, 'h7b, 'hf2, 'h6b, 'h6f, 'hc5,
        'h30, 'h01, 'h67, 'h2b, 'hfe, 'hd7, 'hab, 'h76,
        'hca, 'h82, 'hc9, 'h7d, 'hfa, 'h59, 'h47, 'hf0,
        'had, 'hd4, 'ha2, 'haf, 'h9c, 'ha4, 'h72, 'hc0,
        'hb7, 'hfd, 'h93, 'h26, 'h36, 'h3f, 'hf7, 'hcc,
        'h34, 'ha5, 'he5, 'hf1, 'h71, 'hd8, 'h31, 'h15,
        'h04, 'hc7, 'h23, 'hc3, 'h18, 'h96, 'h05, 'h9a,
        'h07, 'h12, 'h80, 'he2, 'heb, 'h27, 'hb2, 'h75,
        'h09, 'h83, 'h2c, 'h1a, 'h1b, 'h6e, 'h5a, 'ha0,
        'h52, 'h3b, 'hd6, 'hb3, 'h29, 'he3, 'h2f, 'h84,
        'h53, 'hd1, 'h00, 'hed, 'h20, 'hfc, 'hb1, 'h5b,
        'h6a, 'hcb, 'hbe, 'h39, 'h4a, 'h4c, 'h58, 'hcf,
        'hd0, 'hef, 'haa, 'hfb, 'h43, 'h4d, 'h33, 'h85,
        'h45, 'hf9, 'h02, 'h7f, 'h50, 'h3c, 'h9f, 'ha8,
        'h51, 'ha3, 'h40, 'h8f, 'h92, 'h9d, 'h38, 'hf5,
        'hbc, 'hb6, 'hda, 'h21, 'h10, 'hff, 'hf3, 'hd2,
        'hcd, 'h0c, 'h13, 'hec, 'h5f, 'h97, 'h44, 'h17,
        'hc4, 'ha7, 'h7e, 'h3d, 'h64, 'h5d, 'h19, 'h73,
        'h60, 'h81, 'h4f, 'hdc, 'h22, 'h2a, 'h90, 'h88,
        'h46, 'hee, 'hb8, 'h14, 'hde, 'h5e, 'h0b, 'hdb,
        'he0, 'h32, 'h3a, 'h0a, 'h49, 'h06, 'h24, 'h5c,
        'hc2, 'hd3, 'hac, 'h62, 'h91, 'h95, 'he4, 'h79,
        'he7, 'hc8, 'h37, 'h6d, 'h8d, 'hd5, 'h4e, 'ha9,
        'h6c, 'h56, 'hf4, 'hea, 'h65, 'h7a, 'hae, 'h08,
        'hba, 'h78, 'h25, 'h2e, 'h1c, 'ha6, 'hb4, 'hc6,
        'he8, 'hdd, 'h74, 'h1f, 'h4b, 'hbd, 'h8b, 'h8a,
        'h70, 'h3e, 'hb5, 'h66, 'h48, 'h03, 'hf6, 'h0e,
        'h61, 'h35, 'h57, 'hb9, 'h86, 'hc1, 'h1d, 'h9e,
        'he1, 'hf8, 'h98, 'h11, 'h69, 'hd9, 'h8e, 'h94,
        'h9b, 'h1e, 'h87, 'he9, 'hce, 'h55, 'h28, 'hdf,
        'h8c, 'ha1, 'h89, 'h0d, 'hbf, 'he6, 'h42, 'h68,
        'h41, 'h99, 'h2d, 'h0f, 'hb0, 'h54, 'hbb, 'h16
    };

    //**************************************************************************
    // Byte and word helpers
    //**************************************************************************

    // Rotate one byte position towards row 0
    function automatic word_t rotWord(input word_t w);
        return {w[1], w[2], w[3], w[0]};
    endfunction

    // S-box on each byte of a column
    function automatic word_t subWord(input word_t w);
        word_t result;
        for (int i = 0; i < 4; i++)
        begin
            result[i] = SBOX[w[i]];
        end
        return result;
    endfunction

    // Multiply by x in GF(2^8)
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // MixColumns on one column
    // Each row is a ^ sum ^ 2(a ^ next), same as 2a + 3(next) + the other two
    function automatic word_t mixColumn(input word_t col);
        word_t result;
        byte_t total;
        total = col[0] ^ col[1] ^ col[2] ^ col[3];
        for (int r = 0; r < 4; r++)
        begin
            result[r] = col[r] ^ total ^ xtime(col[r] ^ col[(r + 1) % 4]);
        end
        return result;
    endfunction

endpackage

// ==== CipherRound.sv ====
`timescale 1ns/1ps

module CipherRound
    import AesPkg::*;
#(
    // Set on the tenth stage, which has no MixColumns
    parameter bit lastRound = 1'b0
)
(
    input  logic         clock,
    input  logic         rstN,
    input  roundKey_t    roundKey,
    input  cipherStage_t stageIn,
    output cipherStage_t stageOut
);

    state_u addState;
    state_u subState;
    state_u shiftState;
    state_u mixState;
    state_u nextState;

    //**************************************************************************
    // Round datapath
    //**************************************************************************
    always_comb
    begin
        // AddRoundKey with the key from the matching key round
        addState.bytes = stageIn.state.bytes ^ roundKey;

        // SubBytes
        for (int i = 0; i < 16; i++)
        begin
            subState.bytes[i] = SBOX[addState.bytes[i]];
        end

        // ShiftRows
        // Byte r + 4c is row r of column c, row r rotates left by r
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shiftState.bytes[r + 4 * c] = subState.bytes[r + 4 * ((c + r) % 4)];
            end
        end

        // MixColumns through the column view
        for (int c = 0; c < 4; c++)
        begin
            mixState.cols[c] = mixColumn(shiftState.cols[c]);
        end

        // Final round stops after ShiftRows
        if (lastRound)
        begin
            nextState = shiftState;
        end
        else
        begin
            nextState = mixState;
        end
    end

    //**************************************************************************
    // Stage register
    //**************************************************************************

    // State loads every edge, bubbles carry junk with valid low
    always_ff @(posedge clock)
    begin
        stageOut.state <= nextState;
        if (!rstN)
        begin
            stageOut.valid <= 1'b0;
        end
        else
        begin
            stageOut.valid <= stageIn.valid;
        end
    end

endmodule

// ==== KeyExpansion.sv ====
`timescale 1ns/1ps

module KeyExpansion
    import AesPkg::*;
(
    input  logic                         clock,
    input  logic                         rstN,
    input  block_t                       key,
    output roundKey_t [0:NUM_ROUNDS]     roundKeys
);

    // Round key 0 is the input key itself
    // No register here, stage 1 adds it in the same cycle the key arrives
    assign roundKeys[0] = key;

    //**************************************************************************
    // Key round chain
    //**************************************************************************

    // Round i reads the key registered by round i-1
    // so roundKeys[i] trails the input key by i cycles
    for (genvar i = 1; i <= NUM_ROUNDS; i++)
    begin : gKeyRound
        KeyRound #(
            .ROUND(i)
        ) u_keyRound (
            .clock(clock),
            .rstN(rstN),
            .prevKey(roundKeys[i - 1]),
            .nextKey(roundKeys[i])
        );
    end

endmodule

// ==== KeyRound.sv ====
`timescale 1ns/1ps

module KeyRound
    import AesPkg::*;
#(
    // Key round number, picks the round constant
    parameter ROUND = 1
)
(
    input  logic      clock,
    input  logic      rstN,
    input  roundKey_t prevKey,
    output roundKey_t nextKey
);

    state_u prevView;
    state_u nextView;
    word_t  coreWord;

    // Column access to the previous key
    assign prevView = prevKey;

    //**************************************************************************
    // Next round key
    //**************************************************************************
    always_comb
    begin
        // Schedule core on the last column
        coreWord = subWord(rotWord(prevView.cols[3]));
        coreWord[0] = coreWord[0] ^ RCON[ROUND];

        // First column mixes in the core word
        nextView.cols[0] = prevView.cols[0] ^ coreWord;

        // Remaining columns chain off the one just made
        for (int c = 1; c < 4; c++)
        begin
            nextView.cols[c] = nextView.cols[c - 1] ^ prevView.cols[c];
        end
    end

    // One register per round, lines up with the cipher stage of the same round
    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            nextKey <= '0;
        end
        else
        begin
            nextKey <= nextView.bytes;
        end
    end

endmodule

// ==== sources.f ====
+incdir+.
AesPkg.sv
KeyRound.sv
KeyExpansion.sv
CipherRound.sv
AesEncryptPipe.sv
AesEncryptTb.sv
